// File: Makefile
VERILATOR ?= verilator
TOP ?= doodleGameTb
BUILD ?= obj_dir
FILELIST ?= list.f
VFLAGS ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD) -f $(FILELIST)
	./$(BUILD)/V$(TOP)

clean:
	rm -rf $(BUILD)

// File: list.f
verilog/doodlePkg.sv
verilog/keyDecoder.sv
verilog/gameStateCtrl.sv
verilog/hitDetector.sv
verilog/doodleMotion.sv
verilog/doodleGame.sv
testbench/tbClock.sv
testbench/doodleGameChk.sv
testbench/doodleGameTb.sv

// File: testbench/doodleGameChk.sv
`timescale 1ns/100ps

module doodleGameChk
#(
	parameter int SpringSpeed = 20,
	parameter int MaxFall = 12,
	parameter int ScrollLine = 240
)
(
	input logic Reset,
	input logic frame_clk,
	input doodlePkg::gameStateT state,
	input doodlePkg::velT speed,
	input doodlePkg::coordT scroll,
	input doodlePkg::spritePosT sprite
);

	// scroll is registered, so it follows a play frame
	scrollInPlay: assert property (@(posedge Reset) disable iff (frame_clk)
		(scroll != '0) |-> ($past(state) == doodlePkg::StPlay))
		else $error("scroll set outside play");

	speedRange: assert property (@(posedge Reset) disable iff (frame_clk)
		(int'(speed) >= -SpringSpeed) && (int'(speed) <= MaxFall))
		else $error("speed out of range");

	// a rising sprite in steady play never passes the scroll line
	clampLine: assert property (@(posedge Reset) disable iff (frame_clk)
		($past(state) == doodlePkg::StPlay && $past(state, 2) == doodlePkg::StPlay
			&& $past(speed[9])) |-> (int'(sprite.y) >= ScrollLine))
		else $error("sprite above scroll line");

	menuAfterReset: assert property (@(posedge Reset)
		($past(frame_clk) && !frame_clk) |-> (state == doodlePkg::StMenu))
		else $error("state not menu after reset");

endmodule

bind doodleMotion doodleGameChk
#(
	.SpringSpeed(SpringSpeed),
	.MaxFall(MaxFall),
	.ScrollLine(ScrollLine)
) chk (.*);

// File: testbench/doodleGameTb.sv
`timescale 1ns/100ps

module doodleGameTb;

	localparam int CycleLimit = 3000; // about 1000 frames of phases plus margin
	localparam int JumpSpeed = 12;
	localparam int SpringSpeed = 20;
	localparam int MaxFall = 12;
	localparam int GravityDiv = 3;
	localparam int StepX = 4;
	localparam int ScrollLine = 240;

	logic clk, rst;
	logic [7:0] keycode;
	doodlePkg::objStatusT platforms [8];
	doodlePkg::objStatusT springs [2];
	doodlePkg::spritePosT sprite;
	doodlePkg::velT speed;
	doodlePkg::coordT scroll;
	logic [19:0] score;
	doodlePkg::gameStateT state;
	doodlePkg::difficultyT difficulty;
	logic [7:0] platHit;

	integer seed = 9;
	int cycles = 0;
	// reference model registers
	doodlePkg::gameStateT mState, mPrev;
	int mDiff, mX, mY, mSpeed, mScroll, mScore, mGrav;
	logic [7:0] mLast;

	tbClock clock (.clk(clk), .rst(rst));

	doodleGame DUT
	(
		.Reset(clk),
		.frame_clk(rst),
		.keycode(keycode),
		.platforms(platforms),
		.springs(springs),
		.sprite(sprite),
		.speed(speed),
		.scroll(scroll),
		.score(score),
		.state(state),
		.difficulty(difficulty),
		.platHit(platHit)
	);

	function automatic int randRange(int lo, int hi);
		return lo + int'($unsigned($random(seed)) % (hi - lo + 1));
	endfunction

	function automatic int wrapX(int x);
		return ((x % 640) + 640) % 640;
	endfunction

	function automatic bit objHit(doodlePkg::objStatusT o, int x, int y, int halfW, int halfH);
		int bottom, dx;
		bottom = y + 32;
		dx = (x > int'(o.x)) ? x - int'(o.x) : int'(o.x) - x;
		return o.active && bottom >= int'(o.y) - halfH && bottom <= int'(o.y) + halfH
			&& dx <= halfW + 32;
	endfunction

	task automatic checkValue(string what, int got, int expected);
		if (got != expected)
		begin
			$display("ERR %0t: %s is %0d, expected %0d", $time, what, got, expected);
			$display("Verification failed");
			$fatal(1, "stopping at the first mismatch");
		end
	endtask

	task automatic resetModel();
		mState = doodlePkg::StMenu;
		mPrev = doodlePkg::StMenu;
		mDiff = 1;
		mX = 330;
		mY = 100;
		mSpeed = 0;
		mScroll = 0;
		mScore = 0;
		mGrav = 0;
		mLast = 8'd0;
	endtask

	task automatic stepModel();
		bit press, fall, floor, gStep, pHit, sHit, floorHit;
		int act, ny, fs, slot [3];
		doodlePkg::gameStateT old;
		slot = '{230, 330, 430};
		old = mState;
		press = keycode != 0 && keycode != mLast;
		act = (keycode == 4 || keycode == 80) ? 1 : (keycode == 7 || keycode == 79) ? 2 :
			(keycode == 40) ? 3 : (keycode == 19) ? 4 : 0;
		pHit = 0;
		sHit = 0;
		foreach (platforms[i]) pHit |= objHit(platforms[i], mX, mY, 24, 4);
		foreach (springs[i]) sHit |= objHit(springs[i], mX, mY, 8, 4);
		fall = mSpeed >= 0;
		floor = mY + 32 >= 479;
		ny = mY + mSpeed;
		gStep = mGrav == GravityDiv - 1;
		fs = (gStep && mSpeed < MaxFall) ? mSpeed + 1 : mSpeed;
		floorHit = 0;
		mScroll = 0;
		if (mState == doodlePkg::StMenu)
		begin
			mX = slot[mDiff];
			mScore = 0;
			mGrav = gStep ? 0 : mGrav + 1;
			if (fall && floor)
				mSpeed = -JumpSpeed; // floor bounce in the menu
			else
			begin
				mY = ny;
				mSpeed = fs;
			end
		end
		else if (mState == doodlePkg::StPlay && mPrev == doodlePkg::StMenu)
		begin
			mY = 100;
			mSpeed = 0;
			mScore = 0;
			mGrav = 0;
		end
		else if (mState == doodlePkg::StPlay)
		begin
			mGrav = gStep ? 0 : mGrav + 1;
			if (fall && sHit)
				mSpeed = -SpringSpeed;
			else if (fall && pHit)
				mSpeed = -JumpSpeed;
			else if (fall && floor)
				floorHit = 1;
			else
			begin
				mSpeed = fs;
				if (!fall && ny < ScrollLine)
				begin
					mScroll = ScrollLine - ny;
					mScore = (mScore + mScroll) % (1 << 20);
					mY = ScrollLine;
				end
				else
					mY = ny;
			end
			if (!floorHit)
				mX = wrapX(mX + (act == 1 ? -StepX : act == 2 ? StepX : 0));
		end
		// game state and difficulty
		if (old == doodlePkg::StMenu)
		begin
			if (press && act == 3)
				mState = doodlePkg::StPlay;
			if (press && act == 2)
				mDiff = (mDiff + 1) % 3;
			else if (press && act == 1)
				mDiff = (mDiff + 2) % 3;
		end
		else if (old == doodlePkg::StPlay)
		begin
			if (floorHit)
				mState = doodlePkg::StOver;
			else if (press && act == 4)
				mState = doodlePkg::StPause;
		end
		else if (old == doodlePkg::StPause)
		begin
			if (press && act == 4)
				mState = doodlePkg::StPlay;
		end
		else if (press && act == 3)
			mState = doodlePkg::StMenu;
		mPrev = old;
		mLast = keycode;
	endtask

	task automatic compareOutputs();
		checkValue("state", int'(state), int'(mState));
		checkValue("difficulty", int'(difficulty), mDiff);
		checkValue("x", int'(sprite.x), mX);
		checkValue("y", int'(sprite.y), mY);
		checkValue("speed", int'(speed), mSpeed);
		checkValue("scroll", int'(scroll), mScroll);
		checkValue("score", int'(score), mScore);
		foreach (platforms[i])
			checkValue("platHit", int'(platHit[i]), int'(objHit(platforms[i], mX, mY, 24, 4)));
	endtask

	always @(posedge clk)
	begin
		cycles++;
		if (cycles >= CycleLimit)
		begin
			$display("Verification failed");
			$fatal(1, "timeout, the run did not finish within the cycle limit");
		end
		if (rst)
			resetModel();
		else
			stepModel();
		#1;
		compareOutputs();
	end

	task automatic driveFrame(logic [7:0] code);
		@(negedge clk);
		keycode = code;
	endtask

	task automatic clearObjects();
		foreach (platforms[i]) platforms[i] = '0;
		foreach (springs[i]) springs[i] = '0;
	endtask

	// scatter objects around the sprite's feet
	task automatic placeObjects();
		foreach (platforms[i])
		begin
			platforms[i].active = randRange(0, 3) != 0;
			platforms[i].x = 10'(wrapX(mX + randRange(-70, 70)));
			platforms[i].y = 10'(mY + 32 + randRange(-8, 8));
		end
		foreach (springs[i])
		begin
			springs[i].active = randRange(0, 7) == 0;
			springs[i].x = 10'(wrapX(mX + randRange(-45, 45)));
			springs[i].y = 10'(mY + 32 + randRange(-6, 6));
		end
	endtask

	initial
	begin
		logic [7:0] code;
		int r;
		keycode = 8'd0;
		clearObjects();
		resetModel();
		wait (!rst);
		repeat (60) driveFrame(8'd0); // menu bounce on the floor
		repeat (40)
		begin
			r = randRange(0, 4);
			code = (r == 0) ? 8'd4 : (r == 1) ? 8'd80 : (r == 2) ? 8'd7 : (r == 3) ? 8'd79 : 8'd0;
			repeat (randRange(1, 3)) driveFrame(code);
			driveFrame(8'd0);
		end
		driveFrame(8'd40);
		repeat (400)
		begin
			@(negedge clk);
			r = randRange(0, 19);
			keycode = (r == 0) ? 8'd19 : (r < 4) ? 8'd4 : (r < 7) ? 8'd80 :
				(r < 10) ? 8'd7 : (r < 13) ? 8'd79 : 8'd0;
			placeObjects();
		end
		@(negedge clk);
		clearObjects();
		keycode = 8'd0;
		while (mState != doodlePkg::StOver)
		begin
			if (mState == doodlePkg::StPause)
				driveFrame(8'd19);
			driveFrame(8'd0);
		end
		driveFrame(8'd40);
		repeat (5) driveFrame(8'd0);
		driveFrame(8'd40);
		repeat (120) driveFrame(8'd0);
		checkValue("final state", int'(state), int'(doodlePkg::StOver));
		$display("Verification passed");
		$finish;
	end

endmodule

// File: testbench/tbClock.sv
`timescale 1ns/100ps

module tbClock
#(
	parameter int HalfPeriod = 20,
	parameter int ResetCycles = 3
)
(
	output logic clk,
	output logic rst
);

	initial
	begin
		clk = 1'b0;
		forever #HalfPeriod clk = ~clk;
	end

	// reset drops on a falling edge, away from the sampling edge
	initial
	begin
		rst = 1'b1;
		repeat (ResetCycles) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
	end

endmodule

// File: verilog/doodleGame.sv
`timescale 1ns/100ps

module doodleGame
#(
	parameter int NumPlatforms = 8,
	parameter int NumSprings = 2,
	parameter int PlatHalfW = 24,
	parameter int PlatHalfH = 4,
	parameter int SpringHalfW = 8,
	parameter int SpringHalfH = 4,
	parameter int JumpSpeed = 12,
	parameter int SpringSpeed = 20,
	parameter int MaxFall = 12,
	parameter int GravityDiv = 3,
	parameter int StepX = 4,
	parameter int ScrollLine = 240
)
(
	input logic Reset,
	input logic frame_clk,
	input logic [7:0] keycode,
	input doodlePkg::objStatusT platforms [NumPlatforms],
	input doodlePkg::objStatusT springs [NumSprings],
	output doodlePkg::spritePosT sprite,
	output doodlePkg::velT speed,
	output doodlePkg::coordT scroll,
	output logic [19:0] score,
	output doodlePkg::gameStateT state,
	output doodlePkg::difficultyT difficulty,
	output logic [NumPlatforms-1:0] platHit
);

	doodlePkg::keyActionT action;
	logic press;
	logic floorHit; // play ends on the floor
	logic [NumSprings-1:0] springHit;

	keyDecoder keys
	(
		.Reset(Reset),
		.frame_clk(frame_clk),
		.keycode(keycode),
		.action(action),
		.press(press)
	);

	gameStateCtrl control
	(
		.Reset(Reset),
		.frame_clk(frame_clk),
		.action(action),
		.press(press),
		.floorHit(floorHit),
		.state(state),
		.difficulty(difficulty)
	);

	hitDetector #(.Count(NumPlatforms), .HalfW(PlatHalfW), .HalfH(PlatHalfH)) platDetect
	(
		.sprite(sprite),
		.objects(platforms),
		.hit(platHit)
	);

	hitDetector #(.Count(NumSprings), .HalfW(SpringHalfW), .HalfH(SpringHalfH)) springDetect
	(
		.sprite(sprite),
		.objects(springs),
		.hit(springHit)
	);

	doodleMotion
	#(
		.NumPlatforms(NumPlatforms),
		.NumSprings(NumSprings),
		.JumpSpeed(JumpSpeed),
		.SpringSpeed(SpringSpeed),
		.MaxFall(MaxFall),
		.GravityDiv(GravityDiv),
		.StepX(StepX),
		.ScrollLine(ScrollLine)
	) motion
	(
		.Reset(Reset),
		.frame_clk(frame_clk),
		.state(state),
		.difficulty(difficulty),
		.action(action),
		.platHit(platHit),
		.springHit(springHit),
		.sprite(sprite),
		.speed(speed),
		.scroll(scroll),
		.score(score),
		.floorHit(floorHit)
	);

endmodule

// File: verilog/doodleMotion.sv
`timescale 1ns/100ps

module doodleMotion
#(
	parameter int NumPlatforms = 8,
	parameter int NumSprings = 2,
	parameter int JumpSpeed = 12,
	parameter int SpringSpeed = 20,
	parameter int MaxFall = 12,
	parameter int GravityDiv = 3,
	parameter int StepX = 4,
	parameter int ScrollLine = 240
)
(
	input logic Reset,
	input logic frame_clk,
	input doodlePkg::gameStateT state,
	input doodlePkg::difficultyT difficulty,
	input doodlePkg::keyActionT action,
	input logic [NumPlatforms-1:0] platHit,
	input logic [NumSprings-1:0] springHit,
	output doodlePkg::spritePosT sprite,
	output doodlePkg::velT speed,
	output doodlePkg::coordT scroll,
	output logic [19:0] score,
	output logic floorHit
);

	localparam int CntW = (GravityDiv > 1) ? $clog2(GravityDiv) : 1;

	typedef logic signed [11:0] wideT;

	doodlePkg::gameStateT prevState;
	logic [CntW-1:0] gravCnt, gravNext;
	logic enterPlay, falling, onFloor, gravStep;
	wideT yWide, xWide, newY, excess, xMoved;
	doodlePkg::spritePosT spriteNext;
	doodlePkg::velT speedNext, fallSpeed;
	doodlePkg::coordT scrollNext;
	logic [19:0] scoreNext;

	// new game starts only when coming from the menu, not on resume
	assign enterPlay = (state == doodlePkg::StPlay) && (prevState == doodlePkg::StMenu);

	assign falling = !speed[9]; // speed at or above zero
	assign yWide = wideT'(sprite.y);
	assign xWide = wideT'(sprite.x);
	assign onFloor = (yWide + wideT'(doodlePkg::DoodleSize)) >= wideT'(doodlePkg::ScreenBottom);
	assign newY = yWide + wideT'(speed);
	assign excess = wideT'(ScrollLine) - newY;

	// gravity only bites once every GravityDiv frames
	assign gravStep = (gravCnt == CntW'(GravityDiv - 1));
	assign fallSpeed = (gravStep && (speed < doodlePkg::velT'(MaxFall))) ?
		speed + doodlePkg::velT'(1) : speed;

	// sideways step with wrap at the screen edges
	always_comb
	begin
		xMoved = xWide;
		if (action == doodlePkg::ActLeft)
			xMoved = xWide - wideT'(StepX);
		else if (action == doodlePkg::ActRight)
			xMoved = xWide + wideT'(StepX);
		if (xMoved < 0)
			xMoved = xMoved + wideT'(doodlePkg::ScreenWidth);
		else if (xMoved >= wideT'(doodlePkg::ScreenWidth))
			xMoved = xMoved - wideT'(doodlePkg::ScreenWidth);
	end

	always_comb
	begin
		spriteNext = sprite;
		speedNext = speed;
		scrollNext = '0;
		scoreNext = score;
		gravNext = gravCnt;
		floorHit = 1'b0;

		unique case (state)
			doodlePkg::StMenu:
			begin
				spriteNext.x = doodlePkg::MenuSlotX[difficulty]; // sits on the chosen slot
				scoreNext = '0;
				gravNext = gravStep ? '0 : gravCnt + CntW'(1);
				if (falling && onFloor)
					speedNext = doodlePkg::velT'(-JumpSpeed); // menu sprite bounces on the floor
				else
				begin
					spriteNext.y = newY[9:0];
					speedNext = fallSpeed;
				end
			end

			doodlePkg::StPlay:
			begin
				if (enterPlay)
				begin
					spriteNext.y = doodlePkg::StartY;
					speedNext = '0;
					scoreNext = '0;
					gravNext = '0;
				end
				else
				begin
					gravNext = gravStep ? '0 : gravCnt + CntW'(1);
					spriteNext.x = xMoved[9:0];
					if (falling && (|springHit))
						speedNext = doodlePkg::velT'(-SpringSpeed); // springs beat platforms
					else if (falling && (|platHit))
						speedNext = doodlePkg::velT'(-JumpSpeed);
					else if (falling && onFloor)
					begin
						floorHit = 1'b1;
						spriteNext.x = sprite.x; // frozen on the way out
					end
					else
					begin
						speedNext = fallSpeed;
						// rising past the line scrolls the world instead of the sprite
						if (speed[9] && (newY < wideT'(ScrollLine)))
						begin
							spriteNext.y = doodlePkg::coordT'(ScrollLine);
							scrollNext = excess[9:0];
							scoreNext = score + {10'd0, excess[9:0]};
						end
						else
							spriteNext.y = newY[9:0];
					end
				end
			end

			default: ; // pause and game over hold everything
		endcase
	end

	always_ff @(posedge Reset or posedge frame_clk)
	begin
		if (frame_clk)
		begin
			sprite.x <= doodlePkg::MenuSlotX[doodlePkg::DiffNormal];
			sprite.y <= doodlePkg::StartY;
			speed <= '0;
			scroll <= '0;
			score <= '0;
			gravCnt <= '0;
			prevState <= doodlePkg::StMenu;
		end
		else
		begin
			sprite <= spriteNext;
			speed <= speedNext;
			scroll <= scrollNext;
			score <= scoreNext;
			gravCnt <= gravNext;
			prevState <= state;
		end
	end

endmodule

// File: verilog/doodlePkg.sv
package doodlePkg;

	typedef logic [9:0] coordT; // screen pixel coordinate
	typedef logic signed [9:0] velT; // pixels per frame, negative is up

	typedef enum logic [1:0]
	{
		StMenu,
		StPlay,
		StPause,
		StOver
	} gameStateT;

	typedef enum logic [2:0]
	{
		ActNone,
		ActLeft,
		ActRight,
		ActStart,
		ActPause
	} keyActionT;

	typedef enum logic [1:0]
	{
		DiffEasy,
		DiffNormal,
		DiffHard
	} difficultyT;

	typedef struct packed
	{
		coordT x;
		coordT y;
	} spritePosT;

	// one platform or spring, centre position
	typedef struct packed
	{
		coordT x;
		coordT y;
		logic active;
	} objStatusT;

	// keyboard codes, arrows and letters both steer
	localparam logic [7:0] KeyLeftA = 8'd4;
	localparam logic [7:0] KeyLeftB = 8'd80;
	localparam logic [7:0] KeyRightA = 8'd7;
	localparam logic [7:0] KeyRightB = 8'd79;
	localparam logic [7:0] KeyStart = 8'd40;
	localparam logic [7:0] KeyPause = 8'd19;

	localparam coordT ScreenWidth = 10'd640;
	localparam coordT ScreenBottom = 10'd479;
	localparam coordT DoodleSize = 10'd32; // half width and bottom offset
	localparam coordT StartY = 10'd100;

	// menu slot centres for easy, normal and hard
	localparam coordT MenuSlotX [3] = '{10'd230, 10'd330, 10'd430};

endpackage

// File: verilog/gameStateCtrl.sv
`timescale 1ns/100ps

module gameStateCtrl
(
	input logic Reset,
	input logic frame_clk,
	input doodlePkg::keyActionT action,
	input logic press,
	input logic floorHit,
	output doodlePkg::gameStateT state,
	output doodlePkg::difficultyT difficulty
);

	logic startPress, pausePress, leftPress, rightPress;

	assign startPress = press && (action == doodlePkg::ActStart);
	assign pausePress = press && (action == doodlePkg::ActPause);
	assign leftPress = press && (action == doodlePkg::ActLeft);
	assign rightPress = press && (action == doodlePkg::ActRight);

	always_ff @(posedge Reset or posedge frame_clk)
	begin
		if (frame_clk)
		begin
			state <= doodlePkg::StMenu;
			difficulty <= doodlePkg::DiffNormal;
		end
		else
		begin
			unique case (state)
				doodlePkg::StMenu:
				begin
					if (startPress)
						state <= doodlePkg::StPlay;
					// difficulty slots wrap around in both directions
					if (rightPress)
					begin
						unique case (difficulty)
							doodlePkg::DiffEasy: difficulty <= doodlePkg::DiffNormal;
							doodlePkg::DiffNormal: difficulty <= doodlePkg::DiffHard;
							default: difficulty <= doodlePkg::DiffEasy;
						endcase
					end
					else if (leftPress)
					begin
						unique case (difficulty)
							doodlePkg::DiffEasy: difficulty <= doodlePkg::DiffHard;
							doodlePkg::DiffHard: difficulty <= doodlePkg::DiffNormal;
							default: difficulty <= doodlePkg::DiffEasy;
						endcase
					end
				end
				doodlePkg::StPlay:
				begin
					if (floorHit)
						state <= doodlePkg::StOver; // floor wins over a pause in the same frame
					else if (pausePress)
						state <= doodlePkg::StPause;
				end
				doodlePkg::StPause:
				begin
					if (pausePress)
						state <= doodlePkg::StPlay;
				end
				default:
				begin
					if (startPress)
						state <= doodlePkg::StMenu; // back from game over
				end
			endcase
		end
	end

endmodule

// File: verilog/hitDetector.sv
`timescale 1ns/100ps

module hitDetector
#(
	parameter int Count = 8,
	parameter int HalfW = 24,
	parameter int HalfH = 4
)
(
	input doodlePkg::spritePosT sprite,
	input doodlePkg::objStatusT objects [Count],
	output logic [Count-1:0] hit
);

	typedef logic signed [11:0] wideT; // room for sums and differences without wrap

	wideT bottom, centreX;

	assign bottom = wideT'(sprite.y) + wideT'(doodlePkg::DoodleSize); // feet of the sprite
	assign centreX = wideT'(sprite.x);

	genvar i;
	generate
		for (i = 0; i < Count; i++)
		begin : gObj
			wideT objX, objY, dx;

			assign objX = wideT'(objects[i].x);
			assign objY = wideT'(objects[i].y);
			assign dx = (centreX >= objX) ? centreX - objX : objX - centreX;

			// feet inside the top band and boxes overlapping sideways
			assign hit[i] = objects[i].active
				&& (bottom >= objY - wideT'(HalfH))
				&& (bottom <= objY + wideT'(HalfH))
				&& (dx <= wideT'(HalfW + doodlePkg::DoodleSize));
		end
	endgenerate

endmodule

// File: verilog/keyDecoder.sv
`timescale 1ns/100ps

module keyDecoder
(
	input logic Reset,
	input logic frame_clk,
	input logic [7:0] keycode,
	output doodlePkg::keyActionT action,
	output logic press
);

	logic [7:0] lastCode; // keycode seen in the previous frame

	always_comb
	begin
		unique case (keycode)
			doodlePkg::KeyLeftA, doodlePkg::KeyLeftB:
				action = doodlePkg::ActLeft;
			doodlePkg::KeyRightA, doodlePkg::KeyRightB:
				action = doodlePkg::ActRight;
			doodlePkg::KeyStart:
				action = doodlePkg::ActStart;
			doodlePkg::KeyPause:
				action = doodlePkg::ActPause;
			default:
				action = doodlePkg::ActNone;
		endcase
	end

	// a new nonzero code counts once, holding it does not repeat
	assign press = (keycode != 8'd0) && (keycode != lastCode);

	always_ff @(posedge Reset or posedge frame_clk)
	begin
		if (frame_clk)
			lastCode <= 8'd0;
		else
			lastCode <= keycode;
	end

endmodule
